// File: Makefile
SRCS := $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vsimd_decoder_tb: list.f $(SRCS)
	verilator --binary --assert --top-module simd_decoder_tb -f list.f

run: obj_dir/Vsimd_decoder_tb
	./obj_dir/Vsimd_decoder_tb | tee /dev/stderr | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

// File: list.f
+incdir+verilog
verilog/simd_isa_pkg.sv
verilog/simd_ctrl_pkg.sv
verilog/simd_inst_decode.sv
verilog/group_config_slot.sv
verilog/simd_inst_sequencer.sv
verilog/simd_instruction_decoder.sv
tb/simd_decoder_checker.sv
tb/simd_decoder_tb.sv

// File: tb/simd_decoder_checker.sv
`timescale 1ns/1ps

module simd_decoder_checker (
	input logic clk,
	input logic reset,
	input logic imem_rd_req,
	input logic stall,
	input logic done,
	input logic ready
);

	// no fetch while stalled
	assert property (@(posedge clk) disable iff (reset) !(stall && imem_rd_req))
		else $error("instruction fetch requested while stalled");

	// done lasts a single cycle
	assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else $error("done held for more than one cycle");

	assert property (@(posedge clk) disable iff (reset) !(ready && stall))
		else $error("ready and stall high together");

endmodule

// File: tb/simd_decoder_tb.sv
`timescale 1ns/1ps
`include "simd_decoder_config.svh"

module simd_decoder_tb;

	logic clk;
	logic reset;
	logic start;
	simd_ctrl_pkg::group_id_t group_id_s;
	simd_ctrl_pkg::imem_addr_t group_buf_rd_data;
	logic group_buf_rd_v;
	logic group_buf_rd_req;
	simd_ctrl_pkg::group_id_t group_buf_rd_addr;
	simd_isa_pkg::inst_word_t instruction_in;
	logic instruction_in_v;
	logic ld_mem_simd_done;
	logic st_mem_simd_done;
	logic data_shuffle_done;
	logic simd_tiles_done;
	simd_ctrl_pkg::imem_addr_t imem_rd_address;
	logic imem_rd_req;
	logic inst_v;
	simd_isa_pkg::inst_fields_t fields;
	logic ready;
	logic stall;
	logic in_ld_st;
	logic in_shuffle;
	logic in_single_loop;
	logic done;
	simd_ctrl_pkg::group_id_t ld_st_group_id;
	logic [`SIMD_NUM_GROUPS-1:0] ld_config_done;
	logic [`SIMD_NUM_GROUPS-1:0] st_config_done;

	logic [31:0] imem [0:1023];
	simd_ctrl_pkg::imem_addr_t gbuf [0:`SIMD_NUM_GROUPS-1];
	logic [31:0] exp_q [$];
	logic exp_loop_q [$];
	logic [31:0] last_word;
	logic [31:0] lfsr_state;
	logic [11:0] ref_cnt;
	logic [3:0] ref_grp;
	logic [`SIMD_NUM_GROUPS-1:0] exp_ld;
	logic [`SIMD_NUM_GROUPS-1:0] exp_st;
	logic [9:0] wr_ptr;
	logic [32:0] pipe [0:`SIMD_IMEM_LATENCY-1];

	simd_instruction_decoder simd_instruction_decoder_inst (.*);

	bind simd_instruction_decoder simd_decoder_checker checker_inst (.*);

	always #10 clk = ~clk;

	task automatic stop_with_failure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic report_value(string name, logic [31:0] got, logic [31:0] exp);
		$display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		stop_with_failure();
	endtask

	task automatic report_error(string what);
		$display("ERROR at %0t ns: %s", $time, what);
		stop_with_failure();
	endtask

	// taps 32, 22, 2, 1
	function automatic logic [31:0] random_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] make_word(logic [3:0] op, logic [3:0] fn,
			logic [7:0] d, logic [7:0] s1, logic [7:0] s2);
		return {op, fn, d, s1, s2};
	endfunction

	task automatic put(logic [31:0] w);
		imem[wr_ptr] = w;
		wr_ptr = wr_ptr + 10'd1;
	endtask

	task automatic put_plain(int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			r = random_bits(28);
			put({4'd1, r[27:0]});
		end
	endtask

	// expected accepted words, loops unrolled, flags per group
	function automatic void build_expected(logic [9:0] start_addr);
		logic [9:0] a;
		logic [31:0] w;
		logic [11:0] len;
		int passes;
		int guard;
		a = start_addr;
		guard = 0;
		while (guard < 256) begin
			w = imem[a];
			exp_q.push_back(w);
			exp_loop_q.push_back(1'b0);
			guard++;
			if (w[31:28] == 4'd7 && w[27:24] == 4'd1)
				ref_cnt = w[11:0];
			if (w[31:28] == 4'd10 && w[27:26] == 2'b10)
				ref_grp = {w[25:24], w[23:22]};
			if (w[31:28] == 4'd5 && w[27:24] == 4'd5)
				exp_ld[ref_grp] = 1'b1;
			if (w[31:28] == 4'd5 && w[27:24] == 4'd13)
				exp_st[ref_grp] = 1'b1;
			if (w[31:28] == 4'd10 && w[27:25] == 3'b110)
				break;
			if (w[31:28] == 4'd7 && w[27:24] == 4'd2) begin
				len = w[11:0];
				passes = (ref_cnt == 12'd0) ? 1 : int'(ref_cnt);
				for (int p = 0; p < passes; p++)
					for (int i = 1; i <= int'(len); i++) begin
						exp_q.push_back(imem[a + 10'(i)]);
						exp_loop_q.push_back(1'b1);
					end
				a = a + 10'(len);
			end
			a = a + 10'd1;
		end
	endfunction

	// instruction memory, fixed latency
	always @(negedge clk) begin
		for (int i = `SIMD_IMEM_LATENCY - 1; i > 0; i--)
			pipe[i] <= pipe[i-1];
		pipe[0] <= {imem_rd_req, imem[imem_rd_address]};
		instruction_in_v <= pipe[`SIMD_IMEM_LATENCY-1][32];
		instruction_in <= pipe[`SIMD_IMEM_LATENCY-1][31:0];
	end

	// compare every accepted word against the reference list
	always @(posedge clk) begin
		if (!reset && inst_v) begin
			if (exp_q.size() == 0)
				report_error("word accepted after the end of the expected program");
			assert (32'(fields) == exp_q[0])
				else report_value("fields", 32'(fields), exp_q[0]);
			assert (in_single_loop == exp_loop_q[0])
				else report_value("in_single_loop", 32'(in_single_loop), 32'(exp_loop_q[0]));
			last_word = exp_q.pop_front();
			void'(exp_loop_q.pop_front());
		end
	end

	// answers load, store and permutation stalls after a random delay
	initial begin
		int delay;
		logic shuffle;
		forever begin
			@(posedge clk);
			if (!reset && stall) begin
				shuffle = last_word[31:28] == 4'd8;
				delay = 1 + int'(random_bits(3));
				for (int i = 0; i <= delay; i++) begin
					if (i > 0)
						@(posedge clk);
					assert (stall) else report_value("stall", 32'(stall), 1);
					assert (in_shuffle == shuffle)
						else report_value("in_shuffle", 32'(in_shuffle), 32'(shuffle));
					assert (in_ld_st == !shuffle)
						else report_value("in_ld_st", 32'(in_ld_st), 32'(!shuffle));
				end
				@(negedge clk);
				ld_mem_simd_done = last_word[31:28] == 4'd5 && last_word[27:24] == 4'd5;
				st_mem_simd_done = last_word[31:28] == 4'd5 && last_word[27:24] == 4'd13;
				data_shuffle_done = shuffle;
				@(negedge clk);
				ld_mem_simd_done = 1'b0;
				st_mem_simd_done = 1'b0;
				data_shuffle_done = 1'b0;
				// stall ends one cycle after the done input
				assert (!stall) else report_value("stall", 32'(stall), 0);
				assert (!in_ld_st && !in_shuffle)
					else report_error("stall state still active after its done input");
			end
		end
	end

	task automatic run_group(logic [3:0] gid);
		int n;
		build_expected(gbuf[gid]);
		@(negedge clk);
		start = 1'b1;
		group_id_s = gid;
		@(negedge clk);
		start = 1'b0;
		group_id_s = ~gid;
		n = 0;
		while (!group_buf_rd_req) begin
			if (n == 10)
				report_error("no group buffer request after start");
			@(posedge clk);
			n++;
		end
		assert (group_buf_rd_addr == gid)
			else report_value("group_buf_rd_addr", 32'(group_buf_rd_addr), 32'(gid));
		repeat (int'(random_bits(2))) @(negedge clk);
		@(negedge clk);
		group_buf_rd_v = 1'b1;
		group_buf_rd_data = gbuf[gid];
		@(negedge clk);
		group_buf_rd_v = 1'b0;
		n = 0;
		while (!done) begin
			if (n == 2000)
				report_error("no done pulse for the group");
			@(posedge clk);
			n++;
		end
		assert (ready) else report_value("ready", 32'(ready), 1);
		assert (exp_q.size() == 0) else report_value("words left", exp_q.size(), 0);
		@(posedge clk);
		assert (ld_st_group_id == ref_grp)
			else report_value("ld_st_group_id", 32'(ld_st_group_id), 32'(ref_grp));
		assert (ld_config_done == exp_ld)
			else report_value("ld_config_done", 32'(ld_config_done), 32'(exp_ld));
		assert (st_config_done == exp_st)
			else report_value("st_config_done", 32'(st_config_done), 32'(exp_st));
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		group_id_s = '0;
		group_buf_rd_data = '0;
		group_buf_rd_v = 1'b0;
		ld_mem_simd_done = 1'b0;
		st_mem_simd_done = 1'b0;
		data_shuffle_done = 1'b0;
		simd_tiles_done = 1'b0;
		instruction_in = '0;
		instruction_in_v = 1'b0;
		for (int i = 0; i < `SIMD_IMEM_LATENCY; i++)
			pipe[i] = '0;
		lfsr_state = 32'h2cfb_f422;
		ref_cnt = '0;
		ref_grp = '0;
		exp_ld = '0;
		exp_st = '0;
		last_word = '0;
		for (int i = 0; i < 1024; i++)
			imem[i] = {22'h0, 10'(i)};
		for (int g = 0; g < `SIMD_NUM_GROUPS; g++)
			gbuf[g] = {4'(g), 6'h20};
		gbuf[6] = 10'd16;
		gbuf[9] = 10'd64;

		// group 6: straight line, loop 3 x 4, load, store, permutation
		wr_ptr = 10'd16;
		put(make_word(4'd10, 4'b1001, 8'b100_00000, 8'h0, 8'h0));
		put_plain(3);
		put(make_word(4'd7, 4'd1, 8'h0, 8'h0, 8'd3));
		put(make_word(4'd7, 4'd2, 8'h0, 8'h0, 8'd4));
		put_plain(5);
		put(make_word(4'd5, 4'd5, 8'h11, 8'h22, 8'h33));
		put_plain(1);
		put(make_word(4'd5, 4'd13, 8'h44, 8'h55, 8'h66));
		put_plain(1);
		put(make_word(4'd8, 4'd3, 8'h77, 8'h01, 8'h02));
		put_plain(1);
		put(make_word(4'd10, 4'b1100, 8'h0, 8'h0, 8'h0));

		// group 9: load, then a loop that reuses the old count
		wr_ptr = 10'd64;
		put(make_word(4'd10, 4'b1010, 8'b010_00000, 8'h0, 8'h0));
		put_plain(1);
		put(make_word(4'd5, 4'd5, 8'h0a, 8'h0b, 8'h0c));
		put_plain(1);
		put(make_word(4'd7, 4'd2, 8'h0, 8'h0, 8'd2));
		put_plain(3);
		put(make_word(4'd10, 4'b1100, 8'h0, 8'h0, 8'h0));

		repeat (5) @(negedge clk);
		reset = 1'b0;
		assert (ready) else report_value("ready", 32'(ready), 1);

		run_group(4'd6);

		@(negedge clk);
		simd_tiles_done = 1'b1;
		@(negedge clk);
		simd_tiles_done = 1'b0;
		exp_ld = '0;
		@(posedge clk);
		assert (ld_config_done == exp_ld)
			else report_value("ld_config_done", 32'(ld_config_done), 32'(exp_ld));
		assert (st_config_done == exp_st)
			else report_value("st_config_done", 32'(st_config_done), 32'(exp_st));

		run_group(4'd9);

		repeat (3) @(posedge clk);
		if (exp_q.size() == 0 && ready) begin
			$display("Simulation passed");
			$finish;
		end else begin
			report_error("run ended with words still expected or not ready");
		end
	end

endmodule

// File: verilog/group_config_slot.sv
`timescale 1ns/1ps

module group_config_slot #(
	parameter int SLOT_ID = 0
) (
	input  logic                     clk,
	input  logic                     reset,
	input  simd_ctrl_pkg::group_id_t group_id,
	input  logic                     ld_start,
	input  logic                     st_start,
	input  logic                     simd_tiles_done,
	output logic                     ld_done,
	output logic                     st_done
);

	logic hit;

	assign hit = (group_id == simd_ctrl_pkg::group_id_t'(SLOT_ID));

	// load flag drops again once all tiles are through
	always_ff @(posedge clk) begin
		if (reset || simd_tiles_done)
			ld_done <= 1'b0;
		else if (ld_start && hit)
			ld_done <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset)
			st_done <= 1'b0;
		else if (st_start && hit)
			st_done <= 1'b1;
	end

endmodule

// File: verilog/simd_ctrl_pkg.sv
`include "simd_decoder_config.svh"

package simd_ctrl_pkg;

	typedef enum logic [2:0] {
		IDLE,
		GET_GROUP_START_ADDR,
		INST_READ,
		IN_LOOP,
		LD,
		ST,
		PERMUTATION
	} seq_state_e;

	typedef logic [`SIMD_IMEM_ADDR_W-1:0] imem_addr_t;
	typedef logic [`SIMD_LOOP_W-1:0]      loop_count_t;
	typedef logic [`SIMD_GROUP_ID_W-1:0]  group_id_t;

	// one-hot-ish class of the accepted word
	typedef struct packed {
		logic loop_iter;
		logic loop_start;
		logic ld_start;
		logic st_start;
		logic perm_start;
		logic ex_end;
		logic group_start;
	} inst_class_t;

endpackage

// File: verilog/simd_decoder_config.svh
`ifndef SIMD_DECODER_CONFIG_SVH
`define SIMD_DECODER_CONFIG_SVH

// instruction field widths
`define SIMD_OPCODE_BITS     4
`define SIMD_FN_BITS         4
`define SIMD_NS_ID_BITS      3
`define SIMD_NS_INDEX_BITS   5

`define SIMD_GROUP_ID_W      4
`define SIMD_NUM_GROUPS      16
`define SIMD_IMEM_ADDR_W     10
`define SIMD_LOOP_W          12
`define SIMD_IMEM_LATENCY    2

// function codes
`define SIMD_FN_LOOP_ITER    4'd1
`define SIMD_FN_LOOP_START   4'd2
`define SIMD_FN_LD_START     4'd5
`define SIMD_FN_ST_START     4'd13
`define SIMD_FN_PERM_START   4'd3
// upper three bits of the end-of-execution sync
`define SIMD_FN_EX_END       3'b110

`endif

// File: verilog/simd_inst_decode.sv
`timescale 1ns/1ps
`include "simd_decoder_config.svh"

module simd_inst_decode (
	input  logic                        clk,
	input  logic                        reset,
	input  simd_isa_pkg::inst_word_t    instruction_in,
	input  logic                        accept,
	output simd_isa_pkg::inst_fields_t  fields,
	output simd_ctrl_pkg::inst_class_t  cls,
	output simd_ctrl_pkg::loop_count_t  loop_count,
	output simd_ctrl_pkg::loop_count_t  loop_len,
	output simd_ctrl_pkg::group_id_t    group_id,
	output logic                        ld_start,
	output logic                        st_start
);

	simd_isa_pkg::inst_fields_t raw;
	logic is_loop;
	logic is_ld_st;
	logic is_sync;

	assign raw = simd_isa_pkg::inst_fields_t'(instruction_in);
	assign fields = accept ? raw : '0;

	assign is_loop  = accept && (raw.opcode == simd_isa_pkg::OP_LOOP);
	assign is_ld_st = accept && (raw.opcode == simd_isa_pkg::OP_LD_ST);
	assign is_sync  = accept && (raw.opcode == simd_isa_pkg::OP_SYNC);

	always_comb begin
		cls.loop_iter   = is_loop && (raw.fn == `SIMD_FN_LOOP_ITER);
		cls.loop_start  = is_loop && (raw.fn == `SIMD_FN_LOOP_START);
		cls.ld_start    = is_ld_st && (raw.fn == `SIMD_FN_LD_START);
		cls.st_start    = is_ld_st && (raw.fn == `SIMD_FN_ST_START);
		cls.perm_start  = accept && (raw.opcode == simd_isa_pkg::OP_PERMUTATION) &&
			(raw.fn == `SIMD_FN_PERM_START);
		cls.ex_end      = is_sync && (raw.fn[3:1] == `SIMD_FN_EX_END);
		cls.group_start = is_sync && raw.fn[3] && !raw.fn[2];
	end

	assign ld_start = cls.ld_start;
	assign st_start = cls.st_start;

	// loop count and body length come from the low bits of the word
	always_ff @(posedge clk) begin
		if (reset) begin
			loop_count <= '0;
			loop_len <= '0;
		end else begin
			if (cls.loop_iter)
				loop_count <= instruction_in[`SIMD_LOOP_W-1:0];
			if (cls.loop_start)
				loop_len <= instruction_in[`SIMD_LOOP_W-1:0];
		end
	end

	// group id is split over fn and the dest namespace id
	always_ff @(posedge clk) begin
		if (reset)
			group_id <= '0;
		else if (cls.group_start)
			group_id <= {raw.fn[1:0], raw.dest.ns_id[2:1]};
	end

endmodule

// File: verilog/simd_inst_sequencer.sv
`timescale 1ns/1ps
`include "simd_decoder_config.svh"

module simd_inst_sequencer (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        start,
	input  logic                        group_buf_rd_v,
	input  simd_ctrl_pkg::imem_addr_t   group_buf_rd_data,
	input  logic                        instruction_in_v,
	input  simd_ctrl_pkg::inst_class_t  cls,
	input  simd_ctrl_pkg::loop_count_t  loop_count,
	input  simd_ctrl_pkg::loop_count_t  loop_len,
	input  logic                        ld_mem_simd_done,
	input  logic                        st_mem_simd_done,
	input  logic                        data_shuffle_done,
	output logic                        accept,
	output simd_ctrl_pkg::imem_addr_t   imem_rd_address,
	output logic                        imem_rd_req,
	output logic                        ready,
	output logic                        stall,
	output logic                        in_ld_st,
	output logic                        in_shuffle,
	output logic                        in_single_loop,
	output logic                        done
);

	localparam int CNT_W = $clog2(`SIMD_IMEM_LATENCY + 2);

	simd_ctrl_pkg::seq_state_e  state_q, state_d;
	simd_ctrl_pkg::imem_addr_t  addr_d, dec_addr_q, dec_addr_d;
	simd_ctrl_pkg::imem_addr_t  loop_first_q, loop_last;
	simd_ctrl_pkg::loop_count_t pass_q, pass_d;
	logic                       req_d, stall_d, jump, resume, fetching;
	logic [CNT_W-1:0]           inflight_q, inflight_d, drop_q, drop_d;

	assign fetching = (state_q == simd_ctrl_pkg::INST_READ) || (state_q == simd_ctrl_pkg::IN_LOOP);
	assign accept = fetching && instruction_in_v && (drop_q == '0);
	assign loop_last = loop_first_q + simd_ctrl_pkg::imem_addr_t'(loop_len) - 1'b1;

	// words requested but not yet returned
	assign inflight_d = inflight_q + CNT_W'(imem_rd_req) - CNT_W'(instruction_in_v);
	// a jump discards everything still on its way back
	assign drop_d = jump ? inflight_d :
		(instruction_in_v && (drop_q != '0)) ? drop_q - 1'b1 : drop_q;

	assign resume = ((state_q == simd_ctrl_pkg::LD) && ld_mem_simd_done) ||
		((state_q == simd_ctrl_pkg::ST) && st_mem_simd_done) ||
		((state_q == simd_ctrl_pkg::PERMUTATION) && data_shuffle_done);

	always_comb begin
		state_d = state_q;
		addr_d = imem_rd_req ? imem_rd_address + 1'b1 : imem_rd_address;
		req_d = imem_rd_req;
		dec_addr_d = accept ? dec_addr_q + 1'b1 : dec_addr_q;
		pass_d = pass_q;
		stall_d = stall;
		jump = 1'b0;
		unique case (state_q)
			simd_ctrl_pkg::IDLE: begin
				if (start)
					state_d = simd_ctrl_pkg::GET_GROUP_START_ADDR;
			end
			simd_ctrl_pkg::GET_GROUP_START_ADDR: begin
				if (group_buf_rd_v) begin
					state_d = simd_ctrl_pkg::INST_READ;
					addr_d = group_buf_rd_data;
					dec_addr_d = group_buf_rd_data;
					req_d = 1'b1;
					jump = 1'b1;
				end
			end
			simd_ctrl_pkg::INST_READ, simd_ctrl_pkg::IN_LOOP: begin
				if (cls.ex_end) begin
					state_d = simd_ctrl_pkg::IDLE;
					req_d = 1'b0;
					jump = 1'b1;
				end else if (cls.ld_start || cls.st_start || cls.perm_start) begin
					state_d = cls.ld_start ? simd_ctrl_pkg::LD :
						cls.st_start ? simd_ctrl_pkg::ST : simd_ctrl_pkg::PERMUTATION;
					req_d = 1'b0;
					stall_d = 1'b1;
					jump = 1'b1;
				end else if (cls.loop_start) begin
					state_d = simd_ctrl_pkg::IN_LOOP;
					pass_d = 1;
				end else if (accept && (state_q == simd_ctrl_pkg::IN_LOOP) &&
						(dec_addr_q == loop_last)) begin
					// count of zero falls out as a single pass
					if (pass_q >= loop_count) begin
						state_d = simd_ctrl_pkg::INST_READ;
					end else begin
						pass_d = pass_q + 1'b1;
						addr_d = loop_first_q;
						dec_addr_d = loop_first_q;
						req_d = 1'b1;
						jump = 1'b1;
					end
				end
			end
			default: begin
				// stall states, dec_addr_q already points past the start word
				if (resume) begin
					state_d = simd_ctrl_pkg::INST_READ;
					addr_d = dec_addr_q;
					req_d = 1'b1;
					stall_d = 1'b0;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= simd_ctrl_pkg::IDLE;
			imem_rd_address <= '0;
			imem_rd_req <= 1'b0;
			stall <= 1'b0;
			done <= 1'b0;
			pass_q <= '0;
			inflight_q <= '0;
			drop_q <= '0;
		end else begin
			state_q <= state_d;
			imem_rd_address <= addr_d;
			imem_rd_req <= req_d;
			stall <= stall_d;
			done <= cls.ex_end;
			pass_q <= pass_d;
			inflight_q <= inflight_d;
			drop_q <= drop_d;
		end
	end

	always_ff @(posedge clk) begin
		dec_addr_q <= dec_addr_d;
		if (cls.loop_start)
			loop_first_q <= dec_addr_q + 1'b1;
	end

	assign ready = (state_q == simd_ctrl_pkg::IDLE);
	assign in_ld_st = (state_q == simd_ctrl_pkg::LD) || (state_q == simd_ctrl_pkg::ST);
	assign in_shuffle = (state_q == simd_ctrl_pkg::PERMUTATION);
	assign in_single_loop = (state_q == simd_ctrl_pkg::IN_LOOP);

endmodule

// File: verilog/simd_instruction_decoder.sv
`timescale 1ns/1ps
`include "simd_decoder_config.svh"

module simd_instruction_decoder (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        start,
	input  simd_ctrl_pkg::group_id_t    group_id_s,
	input  simd_ctrl_pkg::imem_addr_t   group_buf_rd_data,
	input  logic                        group_buf_rd_v,
	output logic                        group_buf_rd_req,
	output simd_ctrl_pkg::group_id_t    group_buf_rd_addr,
	input  simd_isa_pkg::inst_word_t    instruction_in,
	input  logic                        instruction_in_v,
	input  logic                        ld_mem_simd_done,
	input  logic                        st_mem_simd_done,
	input  logic                        data_shuffle_done,
	input  logic                        simd_tiles_done,
	output simd_ctrl_pkg::imem_addr_t   imem_rd_address,
	output logic                        imem_rd_req,
	output logic                        inst_v,
	output simd_isa_pkg::inst_fields_t  fields,
	output logic                        ready,
	output logic                        stall,
	output logic                        in_ld_st,
	output logic                        in_shuffle,
	output logic                        in_single_loop,
	output logic                        done,
	output simd_ctrl_pkg::group_id_t    ld_st_group_id,
	output logic [`SIMD_NUM_GROUPS-1:0] ld_config_done,
	output logic [`SIMD_NUM_GROUPS-1:0] st_config_done
);

	simd_ctrl_pkg::inst_class_t cls;
	simd_ctrl_pkg::loop_count_t loop_count, loop_len;
	logic                       accept, ld_start, st_start;

	// group buffer lookup one cycle after start
	always_ff @(posedge clk) begin
		if (reset)
			group_buf_rd_req <= 1'b0;
		else
			group_buf_rd_req <= start;
		group_buf_rd_addr <= group_id_s;
	end

	assign inst_v = accept;

	simd_inst_decode simd_inst_decode_inst (
		.clk            (clk),
		.reset          (reset),
		.instruction_in (instruction_in),
		.accept         (accept),
		.fields         (fields),
		.cls            (cls),
		.loop_count     (loop_count),
		.loop_len       (loop_len),
		.group_id       (ld_st_group_id),
		.ld_start       (ld_start),
		.st_start       (st_start)
	);

	simd_inst_sequencer simd_inst_sequencer_inst (
		.clk               (clk),
		.reset             (reset),
		.start             (start),
		.group_buf_rd_v    (group_buf_rd_v),
		.group_buf_rd_data (group_buf_rd_data),
		.instruction_in_v  (instruction_in_v),
		.cls               (cls),
		.loop_count        (loop_count),
		.loop_len          (loop_len),
		.ld_mem_simd_done  (ld_mem_simd_done),
		.st_mem_simd_done  (st_mem_simd_done),
		.data_shuffle_done (data_shuffle_done),
		.accept            (accept),
		.imem_rd_address   (imem_rd_address),
		.imem_rd_req       (imem_rd_req),
		.ready             (ready),
		.stall             (stall),
		.in_ld_st          (in_ld_st),
		.in_shuffle        (in_shuffle),
		.in_single_loop    (in_single_loop),
		.done              (done)
	);

	generate
		for (genvar g = 0; g < `SIMD_NUM_GROUPS; g++) begin : gen_slot
			group_config_slot #(
				.SLOT_ID (g)
			) group_config_slot_inst (
				.clk             (clk),
				.reset           (reset),
				.group_id        (ld_st_group_id),
				.ld_start        (ld_start),
				.st_start        (st_start),
				.simd_tiles_done (simd_tiles_done),
				.ld_done         (ld_config_done[g]),
				.st_done         (st_config_done[g])
			);
		end
	endgenerate

endmodule

// File: verilog/simd_isa_pkg.sv
`include "simd_decoder_config.svh"

package simd_isa_pkg;

	typedef enum logic [`SIMD_OPCODE_BITS-1:0] {
		OP_LD_ST       = 4'd5,
		OP_LOOP        = 4'd7,
		OP_PERMUTATION = 4'd8,
		OP_SYNC        = 4'd10
	} opcode_e;

	typedef logic [`SIMD_FN_BITS-1:0]       fn_t;
	typedef logic [`SIMD_NS_ID_BITS-1:0]    ns_id_t;
	typedef logic [`SIMD_NS_INDEX_BITS-1:0] ns_index_t;

	// namespace id above index, as in the word
	typedef struct packed {
		ns_id_t    ns_id;
		ns_index_t ns_index;
	} operand_t;

	// msb first: opcode, fn, dest, src1, src2
	typedef struct packed {
		opcode_e  opcode;
		fn_t      fn;
		operand_t dest;
		operand_t src1;
		operand_t src2;
	} inst_fields_t;

	typedef logic [$bits(inst_fields_t)-1:0] inst_word_t;

endpackage
